//--- verilog.f
logic/dma_pkg.sv
logic/mem_bus_if.sv
logic/dma_bridge.sv
logic/mem_arbiter.sv
logic/wait_state_sram.sv
logic/dma_subsys.sv
verif/tb_clock_gen.sv
verif/tb_dma_subsys.sv

//--- run_sim.sh
#!/bin/sh
# builds the copy subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_dma_subsys -Mdir obj_dir -f verilog.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dma_subsys > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB PASSED" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1

//--- verif/tb_dma_subsys.sv
// testbench for the copy subsystem, table driven copies checked against a memory model
`timescale 1ns/10ps

module tb_dma_subsys;

    typedef struct packed {
        logic [dma_pkg::awidth-1:0]    src;
        logic [dma_pkg::awidth-1:0]    dst;
        logic [dma_pkg::len_width-1:0] len;
        logic                          probe;
        logic [31:0]                   exp_cycles;
    } copy_case_t;

    localparam int num_cases = 6;

    // source, destination, words, host read during copy, cycles from start edge to done
    localparam copy_case_t cases [num_cases] = '{
        '{32'h0000_0000, 32'h0000_0100, 16'd4,  1'b0, 32'd29},
        '{32'h0000_0040, 32'h0000_0200, 16'd0,  1'b0, 32'd1},
        '{32'h0000_0080, 32'h0000_0300, 16'd8,  1'b1, 32'd57},
        '{32'h0000_0010, 32'h0000_0018, 16'd4,  1'b0, 32'd29},
        '{32'h0000_03c0, 32'h0000_02c0, 16'd1,  1'b1, 32'd8},
        '{32'h0000_00c0, 32'h0000_01a0, 16'd12, 1'b0, 32'd85}
    };

    logic                           clk;
    logic                           rst_n;
    logic                           start_dma;
    logic [dma_pkg::awidth-1:0]     src_addr;
    logic [dma_pkg::awidth-1:0]     dst_addr;
    logic [dma_pkg::len_width-1:0]  length;
    logic                           dma_busy;
    logic                           dma_done;
    logic [dma_pkg::awidth-1:0]     host_addr;
    logic [dma_pkg::dwidth-1:0]     host_wdata;
    logic                           host_rd;
    logic                           host_wr;
    logic [dma_pkg::dwidth-1:0]     host_rdata;
    logic                           host_ready;

    logic [31:0] model_mem [dma_pkg::sram_words];
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          cycle_limit;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dma_subsys UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_dma  (start_dma),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .length     (length),
        .dma_busy   (dma_busy),
        .dma_done   (dma_done),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rd    (host_rd),
        .host_wr    (host_wr),
        .host_rdata (host_rdata),
        .host_ready (host_ready)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [31:0] word);
        int b;
        word = '0;
        for (b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word = {word[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {8'hc3, idx, ~idx, idx ^ 8'h5a};
    endfunction

    // 8 bit word index above a 2 bit byte offset
    function automatic logic [7:0] word_index(input logic [31:0] addr);
        return addr[9:2];
    endfunction

    function automatic int limit_for_table();
        int total;
        int hosts;
        int i;
        total = 100;
        hosts = 2 + dma_pkg::sram_words;
        for (i = 0; i < num_cases; i++) begin
            total += 7 * int'(cases[i].len) + 20;
            hosts += 2 * int'(cases[i].len) + 3 + int'(cases[i].probe);
        end
        return total + 3 * (dma_pkg::wait_states + 1) * hosts;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    task automatic host_request(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data);
        host_addr  = addr;
        host_wdata = data;
        host_rd    = ~wr;
        host_wr    = wr;
    endtask

    // request stays up through the rising edge that completes it
    task automatic host_complete(output logic [31:0] data, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!host_ready);
        data = host_rdata;
        @(negedge clk);
        host_rd = 1'b0;
        host_wr = 1'b0;
    endtask

    task automatic host_access(input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] data);
        int cycles;
        host_request(wr, addr, wdata);
        host_complete(data, cycles);
        check_value("host_ready latency", dma_pkg::wait_states, cycles);
    endtask

    task automatic run_copy(input copy_case_t c);
        logic [31:0] word;
        logic [31:0] data;
        logic [31:0] addr;
        int          cycles;
        int          i;
        for (i = 0; i < int'(c.len); i++) begin
            rand_word(word);
            host_access(1'b1, c.src + 32'(4 * i), word, data);
            model_mem[word_index(c.src + 32'(4 * i))] = word;
        end
        src_addr  = c.src;
        dst_addr  = c.dst;
        length    = c.len;
        start_dma = 1'b1;
        // ascending word order, so overlapping ranges copy forward
        for (i = 0; i < int'(c.len); i++) begin
            model_mem[word_index(c.dst + 32'(4 * i))] = model_mem[word_index(c.src + 32'(4 * i))];
        end
        @(negedge clk);
        check_value("dma_busy", 32'd1, dma_busy);
        check_value("dma_done", 32'd0, dma_done);
        if (c.probe) begin
            host_request(1'b0, c.dst, '0);
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!dma_done) begin
                check_value("dma_busy", 32'd1, dma_busy);
                if (c.probe) begin
                    check_value("host_ready", 32'd0, host_ready);
                end
            end
        end while (!dma_done);
        check_value("dma_done latency", c.exp_cycles, cycles);
        check_value("dma_busy", 32'd0, dma_busy);
        if (c.probe) begin
            host_complete(data, cycles);
            check_value("host_rdata", model_mem[word_index(c.dst)], data);
            check_value("dma_done", 32'd1, dma_done);
        end
        repeat (2) begin
            @(negedge clk);
            check_value("dma_done", 32'd1, dma_done);
            check_value("dma_busy", 32'd0, dma_busy);
        end
        start_dma = 1'b0;
        @(negedge clk);
        check_value("dma_done", 32'd0, dma_done);
        check_value("dma_busy", 32'd0, dma_busy);
        // destination plus one word on each side
        for (i = -1; i <= int'(c.len) + 1; i++) begin
            addr = c.dst + 32'(4 * i);
            host_access(1'b0, addr, '0, data);
            check_value($sformatf("host_rdata at 0x%08h", addr), model_mem[word_index(addr)], data);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, a copy or host access never finished",
                               cycle_count));
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] data;
        int          i;
        cycle_limit = limit_for_table();
        lfsr_state  = 32'h086c949c;
        start_dma   = 1'b0;
        src_addr    = '0;
        dst_addr    = '0;
        length      = '0;
        host_addr   = '0;
        host_wdata  = '0;
        host_rd     = 1'b0;
        host_wr     = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        check_value("dma_busy", 32'd0, dma_busy);
        check_value("dma_done", 32'd0, dma_done);
        check_value("host_ready", 32'd0, host_ready);
        rand_word(word);
        host_access(1'b1, 32'h0000_03fc, word, data);
        host_access(1'b0, 32'h0000_03fc, '0, data);
        check_value("host_rdata", word, data);
        // known contents everywhere before any copy
        for (i = 0; i < dma_pkg::sram_words; i++) begin
            host_access(1'b1, 32'(4 * i), fill_word(8'(i)), data);
            model_mem[i] = fill_word(8'(i));
        end
        for (i = 0; i < num_cases; i++) begin
            run_copy(cases[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock and reset source, 10 ns period with an 8 cycle active low reset
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- logic/dma_subsys.sv
// copy subsystem top, DMA bridge and host port sharing one wait state SRAM
`timescale 1ns/10ps

module dma_subsys (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_dma,
    input  logic [dma_pkg::awidth-1:0]     src_addr,
    input  logic [dma_pkg::awidth-1:0]     dst_addr,
    input  logic [dma_pkg::len_width-1:0]  length,
    output logic                           dma_busy,
    output logic                           dma_done,
    input  logic [dma_pkg::awidth-1:0]     host_addr,
    input  logic [dma_pkg::dwidth-1:0]     host_wdata,
    input  logic                           host_rd,
    input  logic                           host_wr,
    output logic [dma_pkg::dwidth-1:0]     host_rdata,
    output logic                           host_ready
);

    mem_bus_if dma_bus ();
    mem_bus_if sram_bus ();

    dma_bridge u_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_dma (start_dma),
        .src_addr  (src_addr),
        .dst_addr  (dst_addr),
        .length    (length),
        .dma_busy  (dma_busy),
        .dma_done  (dma_done),
        .mem       (dma_bus)
    );

    // busy also locks the host out of the SRAM
    mem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .dma_busy   (dma_busy),
        .dma        (dma_bus),
        .sram       (sram_bus),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rd    (host_rd),
        .host_wr    (host_wr),
        .host_rdata (host_rdata),
        .host_ready (host_ready)
    );

    wait_state_sram u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sram_bus)
    );

endmodule

//--- logic/wait_state_sram.sv
// word addressed SRAM that answers a held request after fixed wait cycles
`timescale 1ns/10ps

module wait_state_sram (
    input  logic         clk,
    input  logic         rst_n,
    mem_bus_if.responder bus
);

    logic [dma_pkg::dwidth-1:0]         mem [dma_pkg::sram_words];
    logic [dma_pkg::wait_cnt_width-1:0] wait_cnt;
    logic [dma_pkg::word_idx_width-1:0] word_idx;
    logic                               req;

    assign req      = bus.rd | bus.wr;
    assign word_idx = bus.addr.fields.word_idx;

    // wait count restarts after every completed access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!req || bus.ready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign bus.ready = req && (wait_cnt == dma_pkg::wait_last);

    // write lands on the ready edge
    always_ff @(posedge clk) begin
        if (bus.ready && bus.wr) begin
            mem[word_idx] <= bus.wdata;
        end
    end

    assign bus.rdata = mem[word_idx];

endmodule

//--- logic/mem_arbiter.sv
// SRAM arbiter between the DMA engine and the host port, grant held per access
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dma_busy,
    mem_bus_if.responder                dma,
    mem_bus_if.requester                sram,
    input  logic [dma_pkg::awidth-1:0]  host_addr,
    input  logic [dma_pkg::dwidth-1:0]  host_wdata,
    input  logic                        host_rd,
    input  logic                        host_wr,
    output logic [dma_pkg::dwidth-1:0]  host_rdata,
    output logic                        host_ready
);

    logic [1:0] owner;
    logic [1:0] sel;
    logic       dma_req;
    logic       host_req;

    assign dma_req  = dma.rd | dma.wr;
    // host locked out for the whole copy
    assign host_req = (host_rd | host_wr) & ~dma_busy;

    // current owner keeps the SRAM, otherwise DMA first
    always_comb begin
        if (owner != dma_pkg::own_none) begin
            sel = owner;
        end else if (dma_req) begin
            sel = dma_pkg::own_dma;
        end else if (host_req) begin
            sel = dma_pkg::own_host;
        end else begin
            sel = dma_pkg::own_none;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= dma_pkg::own_none;
        end else if (sram.ready) begin
            owner <= dma_pkg::own_none;
        end else begin
            owner <= sel;
        end
    end

    always_comb begin
        sram.addr.raw = dma.addr.raw;
        sram.wdata    = dma.wdata;
        sram.rd       = 1'b0;
        sram.wr       = 1'b0;
        if (sel == dma_pkg::own_dma) begin
            sram.rd = dma.rd;
            sram.wr = dma.wr;
        end else if (sel == dma_pkg::own_host) begin
            sram.addr.raw = host_addr;
            sram.wdata    = host_wdata;
            sram.rd       = host_rd;
            sram.wr       = host_wr;
        end
    end

    assign dma.rdata  = sram.rdata;
    assign host_rdata = sram.rdata;
    assign dma.ready  = sram.ready && (sel == dma_pkg::own_dma);
    assign host_ready = sram.ready && (sel == dma_pkg::own_host);

endmodule

//--- logic/dma_bridge.sv
// word copy engine, reads one source word then writes it to the destination
`timescale 1ns/10ps

module dma_bridge (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_dma,
    input  logic [dma_pkg::awidth-1:0]     src_addr,
    input  logic [dma_pkg::awidth-1:0]     dst_addr,
    input  logic [dma_pkg::len_width-1:0]  length,
    output logic                           dma_busy,
    output logic                           dma_done,
    mem_bus_if.requester                   mem
);

    dma_pkg::dma_state_t state;
    dma_pkg::dma_state_t next_state;

    logic [dma_pkg::awidth-1:0]    cur_src;
    logic [dma_pkg::awidth-1:0]    cur_dst;
    logic [dma_pkg::len_width-1:0] remain;
    logic [dma_pkg::dwidth-1:0]    buffer;
    logic                          start_req;
    logic                          last_word;

    assign start_req = (state == dma_pkg::st_idle) && start_dma;
    assign last_word = (remain == dma_pkg::len_width'(1));

    always_comb begin
        next_state = state;
        case (state)
            dma_pkg::st_idle: begin
                if (start_dma) begin
                    // nothing to move, finish at once
                    if (length == '0) begin
                        next_state = dma_pkg::st_done;
                    end else begin
                        next_state = dma_pkg::st_read;
                    end
                end
            end
            dma_pkg::st_read: begin
                if (mem.ready) begin
                    next_state = dma_pkg::st_write;
                end
            end
            dma_pkg::st_write: begin
                if (mem.ready) begin
                    next_state = dma_pkg::st_step;
                end
            end
            dma_pkg::st_step: begin
                if (last_word) begin
                    next_state = dma_pkg::st_done;
                end else begin
                    next_state = dma_pkg::st_read;
                end
            end
            dma_pkg::st_done: begin
                // first done cycle still has busy set
                if (!dma_busy && !start_dma) begin
                    next_state = dma_pkg::st_idle;
                end
            end
            default: begin
                next_state = dma_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= dma_pkg::st_idle;
            dma_busy <= 1'b0;
            dma_done <= 1'b0;
            remain   <= '0;
        end else begin
            state <= next_state;
            case (state)
                dma_pkg::st_idle: begin
                    if (start_dma) begin
                        dma_busy <= 1'b1;
                        dma_done <= 1'b0;
                        remain   <= length;
                    end
                end
                dma_pkg::st_step: begin
                    remain <= remain - 1'b1;
                end
                dma_pkg::st_done: begin
                    // busy and done swap one cycle after entering done
                    if (dma_busy) begin
                        dma_busy <= 1'b0;
                        dma_done <= 1'b1;
                    end else if (!start_dma) begin
                        dma_done <= 1'b0;
                    end
                end
                default: begin
                    remain <= remain;
                end
            endcase
        end
    end

    // address pointers and the word in flight
    always_ff @(posedge clk) begin
        if (start_req) begin
            cur_src <= src_addr;
            cur_dst <= dst_addr;
        end else if (state == dma_pkg::st_step) begin
            cur_src <= cur_src + dma_pkg::bytes_per_word;
            cur_dst <= cur_dst + dma_pkg::bytes_per_word;
        end
        if ((state == dma_pkg::st_read) && mem.ready) begin
            buffer <= mem.rdata;
        end
    end

    // request decoded straight from the state register
    assign mem.rd       = (state == dma_pkg::st_read);
    assign mem.wr       = (state == dma_pkg::st_write);
    assign mem.addr.raw = (state == dma_pkg::st_write) ? cur_dst : cur_src;
    assign mem.wdata    = buffer;

endmodule

//--- logic/mem_bus_if.sv
// single request/ready memory port between a requester and a responder
`timescale 1ns/10ps

interface mem_bus_if;

    dma_pkg::mem_addr_u          addr;
    logic [dma_pkg::dwidth-1:0]  wdata;
    logic                        rd;
    logic                        wr;
    logic [dma_pkg::dwidth-1:0]  rdata;
    logic                        ready;

    // request held until the cycle with ready high
    modport requester (
        output addr,
        output wdata,
        output rd,
        output wr,
        input  rdata,
        input  ready
    );

    modport responder (
        input  addr,
        input  wdata,
        input  rd,
        input  wr,
        output rdata,
        output ready
    );

endinterface

//--- logic/dma_pkg.sv
// copy subsystem shared widths, SRAM timing, engine states and address decode
package dma_pkg;

    localparam int dwidth = 32;
    localparam int awidth = 32;
    localparam int len_width = 16;
    localparam int bytes_per_word = dwidth / 8;

    // SRAM geometry and access timing
    localparam int sram_words = 256;
    localparam int word_idx_width = $clog2(sram_words);
    localparam int byte_off_width = $clog2(bytes_per_word);
    localparam int wait_states = 2;
    localparam int wait_cnt_width = $clog2(wait_states + 1);
    localparam logic [wait_cnt_width-1:0] wait_last = wait_cnt_width'(wait_states);

    // arbiter owner codes
    localparam logic [1:0] own_none = 2'd0;
    localparam logic [1:0] own_dma  = 2'd1;
    localparam logic [1:0] own_host = 2'd2;

    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_read  = 3'd1,
        st_write = 3'd2,
        st_step  = 3'd3,
        st_done  = 3'd4
    } dma_state_t;

    // byte address, whole or split into word index and byte offset
    typedef union packed {
        logic [awidth-1:0] raw;
        struct packed {
            logic [awidth-word_idx_width-byte_off_width-1:0] unused;
            logic [word_idx_width-1:0]                       word_idx;
            logic [byte_off_width-1:0]                       byte_off;
        } fields;
    } mem_addr_u;

endpackage
